// ==== source/bru_macros.svh ====
`ifndef BRU_MACROS_SVH
`define BRU_MACROS_SVH

// btb geometry
`define BRU_BTB_SETS 16
`define BRU_BTB_IDX_W 4
`define BRU_BTB_TAG_W (30 - `BRU_BTB_IDX_W) // word pc bits above the index

// id widths shared with the rob and rename
`define BRU_ROB_W 6
`define BRU_REG_W 6

`endif

// ==== source/branch_pkg.sv ====
`include "bru_macros.svh"

package branch_pkg;

    typedef logic [29:0] word_pc_t; // byte pc without bits 1:0

    typedef enum logic [1:0] {
        BK_COND = 2'd0,
        BK_CALL = 2'd1,
        BK_JUMP = 2'd2,
        BK_RET  = 2'd3
    } branch_kind_t;

    // funct3 encodings of the conditional branches
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } bnch_cond_t;

    typedef logic [`BRU_ROB_W-1:0] rob_id_t;
    typedef logic [`BRU_REG_W-1:0] reg_id_t;

endpackage

// ==== source/btb_pkg.sv ====
`include "bru_macros.svh"

package btb_pkg;

    import branch_pkg::*;

    typedef logic [1:0] bm_cntr_t; // msb set means predict taken
    typedef logic       btb_way_t;

    parameter bm_cntr_t BM_INIT = 2'd2; // weakly taken

    typedef struct packed {
        logic                      valid;
        logic [`BRU_BTB_TAG_W-1:0] tag;
        word_pc_t                  target;
        branch_kind_t              kind;
        bm_cntr_t                  cntr;
    } btb_entry_t;

endpackage

// ==== source/btb.sv ====
`timescale 1ns/1ps
`include "bru_macros.svh"

module btb import branch_pkg::*, btb_pkg::*; #(
    parameter int SETS = `BRU_BTB_SETS
) (
    input  logic         cpu_clock_i,
    input  logic         rst_n_i,
    input  word_pc_t     lookup_pc_i,
    input  word_pc_t     upd_pc_i,
    input  word_pc_t     upd_target_i,
    input  branch_kind_t upd_kind_i,
    input  logic         upd_taken_i,
    input  btb_way_t     upd_way_i,
    input  logic         upd_hit_i,
    input  logic         upd_alloc_i,
    input  logic         upd_bm_mod_i,
    input  bm_cntr_t     upd_cntr_i,

    output logic         hit_o,
    output btb_way_t     hit_way_o,
    output word_pc_t     target_o,
    output branch_kind_t kind_o,
    output bm_cntr_t     cntr_o
);

    localparam int IDX_W = $clog2(SETS);

    btb_entry_t                mem_q [2][SETS];
    logic                      lru_q [SETS]; // way to replace next
    logic [IDX_W-1:0]          l_idx;
    logic [`BRU_BTB_TAG_W-1:0] l_tag;
    btb_entry_t                e0;
    btb_entry_t                e1;
    logic                      hit0;
    logic                      hit1;
    logic [IDX_W-1:0]          u_idx;
    logic [`BRU_BTB_TAG_W-1:0] u_tag;
    btb_way_t                  alloc_way;
    bm_cntr_t                  cntr_nxt;

    // lookup
    assign l_idx = lookup_pc_i[IDX_W-1:0];
    assign l_tag = lookup_pc_i[29 -: `BRU_BTB_TAG_W];
    assign e0    = mem_q[0][l_idx];
    assign e1    = mem_q[1][l_idx];
    assign hit0  = e0.valid && (e0.tag == l_tag);
    assign hit1  = e1.valid && (e1.tag == l_tag);

    assign hit_o     = hit0 || hit1;
    assign hit_way_o = !hit0;
    assign target_o  = hit0 ? e0.target : e1.target;
    assign kind_o    = hit0 ? e0.kind : e1.kind;
    assign cntr_o    = hit0 ? e0.cntr : e1.cntr;

    // update
    assign u_idx = upd_pc_i[IDX_W-1:0];
    assign u_tag = upd_pc_i[29 -: `BRU_BTB_TAG_W];

    always_comb begin
        if (upd_hit_i)
            alloc_way = upd_way_i;
        else if (!mem_q[0][u_idx].valid)
            alloc_way = 1'b0;
        else if (!mem_q[1][u_idx].valid)
            alloc_way = 1'b1;
        else
            alloc_way = lru_q[u_idx];
    end

    always_comb begin
        if (upd_taken_i)
            cntr_nxt = (upd_cntr_i == 2'd3) ? upd_cntr_i : upd_cntr_i + 2'd1;
        else
            cntr_nxt = (upd_cntr_i == 2'd0) ? upd_cntr_i : upd_cntr_i - 2'd1;
    end

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < SETS; s++) begin
                mem_q[0][s].valid <= 1'b0;
                mem_q[1][s].valid <= 1'b0;
                lru_q[s]          <= 1'b0;
            end
        end else if (upd_alloc_i) begin // fresh entry starts weakly taken
            mem_q[alloc_way][u_idx] <= '{valid: 1'b1, tag: u_tag, target: upd_target_i,
                                         kind: upd_kind_i, cntr: BM_INIT};
            lru_q[u_idx]            <= !alloc_way;
        end else if (upd_bm_mod_i) begin
            mem_q[upd_way_i][u_idx].cntr <= cntr_nxt;
            lru_q[u_idx]                 <= !upd_way_i;
        end
    end

    // both requests come from one hit, so they must name the same way
    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        (upd_alloc_i && upd_bm_mod_i) |-> (upd_hit_i && alloc_way == upd_way_i));

endmodule

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import branch_pkg::*, btb_pkg::*; (
    input  logic         cpu_clock_i,
    input  logic         rst_n_i,
    input  logic         flush_i,
    input  logic         valid_i,
    input  logic [31:0]  operand_1_i,
    input  logic [31:0]  operand_2_i,
    input  logic [31:0]  offset_i,
    input  word_pc_t     pc_i,
    input  logic         auipc_i,
    input  logic         call_i,
    input  logic         ret_i,
    input  logic         jal_i,
    input  logic         jalr_i,
    input  bnch_cond_t   bnch_cond_i,
    input  rob_id_t      rob_id_i,
    input  reg_id_t      dest_i,
    // lookup result for pc_i
    input  logic         btb_vld_i,
    input  btb_way_t     btb_way_i,
    input  word_pc_t     btb_target_i,
    input  branch_kind_t btype_i,
    input  bm_cntr_t     bm_pred_i,

    output logic [31:0]  result_o,
    output logic         wb_valid_o,
    output reg_id_t      wb_dest_o,
    output logic         res_valid_o,
    output rob_id_t      rob_o,
    output logic         rcu_excp_o,
    output word_pc_t     c1_btb_vpc_o,
    output word_pc_t     c1_btb_target_o,
    output bm_cntr_t     c1_cntr_pred_o,
    output logic         c1_bnch_tkn_o,
    output branch_kind_t c1_bnch_type_o,
    output btb_way_t     c1_btb_way_o,
    output logic         c1_btb_hit_o,
    output logic         c1_btb_alloc_o,
    output logic         c1_btb_bm_mod_o,
    output logic         c1_call_affirm_o,
    output logic         c1_ret_affirm_o
);

    logic         eq;
    logic         gt_31;
    logic         sgt;
    logic         ugt;
    logic         cmp_res;
    branch_kind_t kind;
    logic         is_cond;
    logic         taken;
    logic [31:0]  tgt_base;
    logic [31:0]  tgt_add;
    logic [31:0]  target;
    logic         accept;
    logic         hit_ok;
    logic         mispredict;

    assign eq    = operand_1_i == operand_2_i;
    assign gt_31 = operand_1_i[30:0] > operand_2_i[30:0];

    // on differing signs the sign bits alone decide
    assign sgt = (operand_1_i[31] == operand_2_i[31]) ? gt_31 : !operand_1_i[31];
    assign ugt = (operand_1_i[31] == operand_2_i[31]) ? gt_31 : operand_1_i[31];

    always_comb begin
        case (bnch_cond_i)
            BEQ:     cmp_res = eq;
            BNE:     cmp_res = !eq;
            BLT:     cmp_res = !(sgt | eq);
            BGE:     cmp_res = sgt | eq;
            BLTU:    cmp_res = !(ugt | eq);
            BGEU:    cmp_res = ugt | eq;
            default: cmp_res = 1'b0;
        endcase
    end

    always_comb begin
        if (call_i)
            kind = BK_CALL;
        else if (ret_i)
            kind = BK_RET;
        else if (jal_i || jalr_i)
            kind = BK_JUMP;
        else
            kind = BK_COND;
    end

    assign is_cond = !auipc_i && (kind == BK_COND);
    assign taken   = is_cond ? cmp_res : !auipc_i;

    assign tgt_base = jalr_i ? operand_1_i : {pc_i, 2'b00};
    assign tgt_add  = (jal_i || jalr_i || (is_cond && cmp_res)) ? offset_i : 32'd4;
    assign target   = tgt_base + tgt_add;

    assign accept = valid_i && !flush_i;
    assign hit_ok = btb_vld_i && (btb_target_i == target[31:2]) && (btype_i == kind);

    assign mispredict = (!btb_vld_i && taken) ||
                        (btb_vld_i && btb_target_i != target[31:2]) ||
                        (btb_vld_i && btype_i != kind) ||
                        (btb_vld_i && is_cond && (bm_pred_i[1] != cmp_res));

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            res_valid_o      <= 1'b0;
            wb_valid_o       <= 1'b0;
            rcu_excp_o       <= 1'b0;
            c1_btb_alloc_o   <= 1'b0;
            c1_btb_bm_mod_o  <= 1'b0;
            c1_call_affirm_o <= 1'b0;
            c1_ret_affirm_o  <= 1'b0;
        end else begin
            res_valid_o      <= accept;
            wb_valid_o       <= accept && (auipc_i || jal_i || jalr_i) && (dest_i != '0);
            rcu_excp_o       <= accept && !auipc_i && mispredict;
            c1_btb_alloc_o   <= accept && taken && !hit_ok;
            c1_btb_bm_mod_o  <= accept && is_cond && btb_vld_i;
            c1_call_affirm_o <= accept && call_i && hit_ok;
            c1_ret_affirm_o  <= accept && ret_i && hit_ok;
        end
    end

    // payload and training record
    always_ff @(posedge cpu_clock_i) begin
        result_o        <= auipc_i ? {pc_i, 2'b00} + offset_i : {pc_i + 30'd1, 2'b00};
        wb_dest_o       <= dest_i;
        rob_o           <= rob_id_i;
        c1_btb_vpc_o    <= pc_i;
        c1_btb_target_o <= target[31:2];
        c1_cntr_pred_o  <= bm_pred_i;
        c1_bnch_tkn_o   <= taken;
        c1_bnch_type_o  <= kind;
        c1_btb_way_o    <= btb_way_i;
        c1_btb_hit_o    <= btb_vld_i;
    end

    // an affirmed call or return never mispredicts
    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        (c1_call_affirm_o || c1_ret_affirm_o) |-> !rcu_excp_o);

    // every new btb entry follows a misprediction
    assert property (@(posedge cpu_clock_i) disable iff (!rst_n_i)
        c1_btb_alloc_o |-> rcu_excp_o);

endmodule

// ==== source/bru_top.sv ====
`timescale 1ns/1ps

module bru_top import branch_pkg::*, btb_pkg::*; (
    input  logic        cpu_clock_i,
    input  logic        rst_n_i,
    input  logic        valid_i,
    input  logic        flush_i,
    input  logic [31:0] operand_1_i,
    input  logic [31:0] operand_2_i,
    input  logic [31:0] offset_i,
    input  word_pc_t    pc_i,
    input  logic        auipc_i,
    input  logic        call_i,
    input  logic        ret_i,
    input  logic        jal_i,
    input  logic        jalr_i,
    input  bnch_cond_t  bnch_cond_i,
    input  rob_id_t     rob_id_i,
    input  reg_id_t     dest_i,

    output logic [31:0] result_o,
    output logic        wb_valid_o,
    output reg_id_t     wb_dest_o,
    output logic        res_valid_o,
    output rob_id_t     rob_o,
    output logic        rcu_excp_o,
    output logic        call_affirm_o,
    output logic        ret_affirm_o
);

    // lookup in the same cycle as issue
    logic         btb_hit;
    btb_way_t     btb_way;
    word_pc_t     btb_target;
    branch_kind_t btb_kind;
    bm_cntr_t     btb_cntr;

    // training record that the btb writes at the next edge
    word_pc_t     c1_vpc;
    word_pc_t     c1_target;
    bm_cntr_t     c1_cntr;
    logic         c1_taken;
    branch_kind_t c1_kind;
    btb_way_t     c1_way;
    logic         c1_hit;
    logic         c1_alloc;
    logic         c1_bm_mod;

    btb u_btb (
        .cpu_clock_i  (cpu_clock_i),
        .rst_n_i      (rst_n_i),
        .lookup_pc_i  (pc_i),
        .upd_pc_i     (c1_vpc),
        .upd_target_i (c1_target),
        .upd_kind_i   (c1_kind),
        .upd_taken_i  (c1_taken),
        .upd_way_i    (c1_way),
        .upd_hit_i    (c1_hit),
        .upd_alloc_i  (c1_alloc),
        .upd_bm_mod_i (c1_bm_mod),
        .upd_cntr_i   (c1_cntr),
        .hit_o        (btb_hit),
        .hit_way_o    (btb_way),
        .target_o     (btb_target),
        .kind_o       (btb_kind),
        .cntr_o       (btb_cntr)
    );

    branch_unit u_branch_unit (
        .cpu_clock_i      (cpu_clock_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .valid_i          (valid_i),
        .operand_1_i      (operand_1_i),
        .operand_2_i      (operand_2_i),
        .offset_i         (offset_i),
        .pc_i             (pc_i),
        .auipc_i          (auipc_i),
        .call_i           (call_i),
        .ret_i            (ret_i),
        .jal_i            (jal_i),
        .jalr_i           (jalr_i),
        .bnch_cond_i      (bnch_cond_i),
        .rob_id_i         (rob_id_i),
        .dest_i           (dest_i),
        .btb_vld_i        (btb_hit),
        .btb_way_i        (btb_way),
        .btb_target_i     (btb_target),
        .btype_i          (btb_kind),
        .bm_pred_i        (btb_cntr),
        .result_o         (result_o),
        .wb_valid_o       (wb_valid_o),
        .wb_dest_o        (wb_dest_o),
        .res_valid_o      (res_valid_o),
        .rob_o            (rob_o),
        .rcu_excp_o       (rcu_excp_o),
        .c1_btb_vpc_o     (c1_vpc),
        .c1_btb_target_o  (c1_target),
        .c1_cntr_pred_o   (c1_cntr),
        .c1_bnch_tkn_o    (c1_taken),
        .c1_bnch_type_o   (c1_kind),
        .c1_btb_way_o     (c1_way),
        .c1_btb_hit_o     (c1_hit),
        .c1_btb_alloc_o   (c1_alloc),
        .c1_btb_bm_mod_o  (c1_bm_mod),
        .c1_call_affirm_o (call_affirm_o), // to the return stack outside
        .c1_ret_affirm_o  (ret_affirm_o)
    );

endmodule

// ==== verification/tb_bru.sv ====
`timescale 1ns/1ps
`include "bru_macros.svh"

module tb_bru import branch_pkg::*, btb_pkg::*; ();

    // issue flags as {auipc, call, ret, jal, jalr}
    localparam logic [4:0] OP_COND  = 5'b00000;
    localparam logic [4:0] OP_AUIPC = 5'b10000;
    localparam logic [4:0] OP_CALL  = 5'b01010;
    localparam logic [4:0] OP_RET   = 5'b00101;
    localparam logic [4:0] OP_JAL   = 5'b00010;
    localparam logic [4:0] OP_JALR  = 5'b00001;

    logic        cpu_clock;
    logic        rst_n;
    logic        valid;
    logic        flush;
    logic [31:0] operand_1;
    logic [31:0] operand_2;
    logic [31:0] offset;
    word_pc_t    pc;
    logic        auipc;
    logic        call;
    logic        ret;
    logic        jal;
    logic        jalr;
    bnch_cond_t  bnch_cond;
    rob_id_t     rob_id;
    reg_id_t     dest;
    logic [31:0] result;
    logic        wb_valid;
    reg_id_t     wb_dest;
    logic        res_valid;
    rob_id_t     rob;
    logic        rcu_excp;
    logic        call_affirm;
    logic        ret_affirm;

    btb_entry_t  model_q [2][`BRU_BTB_SETS]; // reference copy of the btb
    logic        model_lru [`BRU_BTB_SETS];
    logic [31:0] lfsr;
    string       test_name;
    int          test_errs;
    int          total_errs;
    int          checks;
    int          tests_run;
    int          tests_failed;

    bru_top u_dut (
        .cpu_clock_i   (cpu_clock),
        .rst_n_i       (rst_n),
        .valid_i       (valid),
        .flush_i       (flush),
        .operand_1_i   (operand_1),
        .operand_2_i   (operand_2),
        .offset_i      (offset),
        .pc_i          (pc),
        .auipc_i       (auipc),
        .call_i        (call),
        .ret_i         (ret),
        .jal_i         (jal),
        .jalr_i        (jalr),
        .bnch_cond_i   (bnch_cond),
        .rob_id_i      (rob_id),
        .dest_i        (dest),
        .result_o      (result),
        .wb_valid_o    (wb_valid),
        .wb_dest_o     (wb_dest),
        .res_valid_o   (res_valid),
        .rob_o         (rob),
        .rcu_excp_o    (rcu_excp),
        .call_affirm_o (call_affirm),
        .ret_affirm_o  (ret_affirm)
    );

    initial begin
        cpu_clock = 1'b0;
        forever #10 cpu_clock = ~cpu_clock;
    end

    // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_word();
        logic [31:0] val;
        logic        lsb;
        val = '0;
        for (int i = 0; i < 32; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb)
                lfsr = lfsr ^ 32'h8020_0003;
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    function automatic logic cond_true(input bnch_cond_t c, input logic [31:0] a,
                                       input logic [31:0] b);
        case (c)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            BGEU:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_reg(input string what, input reg_id_t exp, input reg_id_t act);
        checks++;
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_rob(input string what, input rob_id_t exp, input rob_id_t act);
        checks++;
        if (exp !== act) begin
            $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (!res_valid) begin
            if (n == 20) begin
                $display("timeout in %s: no result from the branch unit in 20 cycles", test_name);
                $display("TEST FAILED");
                $finish;
            end
            @(posedge cpu_clock);
            #2;
            n++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic report_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("PASS  %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d mismatches)", test_name, test_errs);
        end
    endtask

    // one instruction checked against the model and one more cycle for btb training
    task automatic issue(input logic [4:0] op, input bnch_cond_t cond, input logic [31:0] op1,
                         input logic [31:0] op2, input logic [31:0] off, input word_pc_t vpc,
                         input reg_id_t rd, input logic kill);
        branch_kind_t k;
        logic         cmp;
        logic         tkn;
        logic         hit;
        logic         hit_ok;
        logic         w;
        logic [31:0]  tgt;
        logic [31:0]  exp_res;
        btb_entry_t   e;
        int           idx;
        k = op[3] ? BK_CALL : op[2] ? BK_RET : (op[1] || op[0]) ? BK_JUMP : BK_COND;
        cmp = cond_true(cond, op1, op2);
        tkn = op[4] ? 1'b0 : (k == BK_COND) ? cmp : 1'b1;
        if (op[0])
            tgt = op1 + off;
        else if (op[1] || (k == BK_COND && !op[4] && cmp))
            tgt = {vpc, 2'b00} + off;
        else
            tgt = {vpc, 2'b00} + 32'd4;
        exp_res = op[4] ? {vpc, 2'b00} + off : {vpc, 2'b00} + 32'd4;
        idx = vpc[`BRU_BTB_IDX_W-1:0];
        hit = 1'b0;
        w   = 1'b0;
        for (int i = 1; i >= 0; i--) begin // way 0 wins on a double match
            if (model_q[i][idx].valid && model_q[i][idx].tag == vpc[29 -: `BRU_BTB_TAG_W]) begin
                hit = 1'b1;
                w   = i[0];
            end
        end
        e = model_q[w][idx];
        hit_ok = hit && e.target == tgt[31:2] && e.kind == k;

        valid     = 1'b1;
        flush     = kill;
        {auipc, call, ret, jal, jalr} = op;
        bnch_cond = cond;
        operand_1 = op1;
        operand_2 = op2;
        offset    = off;
        pc        = vpc;
        dest      = rd;
        @(posedge cpu_clock);
        #2;
        valid = 1'b0;
        flush = 1'b0;
        if (kill) begin
            check_bit("res_valid", 1'b0, res_valid);
            check_bit("rcu_excp", 1'b0, rcu_excp);
        end else begin
            wait_result();
            check_word("result", exp_res, result);
            check_bit("wb_valid", (op[4] || op[1] || op[0]) && rd != '0, wb_valid);
            check_reg("wb_dest", rd, wb_dest);
            check_rob("rob", rob_id, rob);
            check_bit("rcu_excp", !op[4] && ((!hit && tkn) || (hit && !hit_ok) ||
                      (hit && k == BK_COND && e.cntr[1] != cmp)), rcu_excp);
            check_bit("call_affirm", op[3] && hit_ok, call_affirm);
            check_bit("ret_affirm", op[2] && hit_ok, ret_affirm);
            if (tkn && !hit_ok) begin
                if (!hit)
                    w = !model_q[0][idx].valid ? 1'b0 : !model_q[1][idx].valid ? 1'b1
                                                                               : model_lru[idx];
                model_q[w][idx] = '{valid: 1'b1, tag: vpc[29 -: `BRU_BTB_TAG_W],
                                    target: tgt[31:2], kind: k, cntr: BM_INIT};
                model_lru[idx] = !w;
            end else if (k == BK_COND && !op[4] && hit) begin
                if (cmp && e.cntr != 2'd3)
                    model_q[w][idx].cntr = e.cntr + 2'd1;
                else if (!cmp && e.cntr != 2'd0)
                    model_q[w][idx].cntr = e.cntr - 2'd1;
                model_lru[idx] = !w;
            end
        end
        rob_id = rob_id + 1'b1;
        @(posedge cpu_clock);
        #2;
    endtask

    task automatic test_conditions();
        bnch_cond_t  conds [6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        logic [31:0] a;
        logic [31:0] b;
        start_test("compare conditions");
        for (int c = 0; c < 6; c++) begin
            for (int k = 0; k < 5; k++) begin
                a = rand_word();
                b = rand_word();
                case (k)
                    0: b = a;
                    1: begin
                        a = 32'h8000_0000;
                        b = 32'h0000_0001;
                    end
                    2: begin
                        a = 32'h0000_0001;
                        b = 32'h8000_0000;
                    end
                    3: begin
                        a = 32'hffff_ffff;
                        b = 32'h0000_0000;
                    end
                    default: ;
                endcase
                // nonzero rd, a conditional still writes nothing back
                issue(OP_COND, conds[c], a, b, rand_word() & 32'h0000_0ffc,
                      30'h400 + c * 5 + k, 6'd9, 1'b0);
            end
        end
        report_test();
    endtask

    task automatic test_jumps();
        logic [31:0] a;
        start_test("jal and jalr");
        a = rand_word();
        issue(OP_JAL, BEQ, 32'd0, 32'd0, 32'h100, 30'h800, 6'd5, 1'b0); // cold miss
        issue(OP_JAL, BEQ, 32'd0, 32'd0, 32'h100, 30'h800, 6'd5, 1'b0);
        issue(OP_JAL, BEQ, 32'd0, 32'd0, 32'h40, 30'h801, 6'd0, 1'b0);
        issue(OP_JALR, BEQ, a, 32'd0, 32'h10, 30'h900, 6'd7, 1'b0);
        issue(OP_JALR, BEQ, a, 32'd0, 32'h10, 30'h900, 6'd7, 1'b0);
        issue(OP_JALR, BEQ, a ^ 32'h100, 32'd0, 32'h10, 30'h900, 6'd7, 1'b0);
        report_test();
    endtask

    task automatic test_auipc();
        logic [31:0] p;
        start_test("auipc");
        for (int i = 0; i < 6; i++) begin
            p = rand_word();
            issue(OP_AUIPC, BEQ, rand_word(), rand_word(), rand_word(), p[29:0], 6'd3, 1'b0);
        end
        report_test();
    endtask

    task automatic test_bimodal();
        logic [31:0] a;
        start_test("bimodal training");
        a = rand_word();
        for (int i = 0; i < 4; i++)
            issue(OP_COND, BEQ, a, a, 32'h80, 30'hA00, 6'd0, 1'b0);
        for (int i = 0; i < 5; i++)
            issue(OP_COND, BEQ, a, a + 1, 32'h80, 30'hA00, 6'd0, 1'b0);
        for (int i = 0; i < 3; i++)
            issue(OP_COND, BEQ, a, a, 32'h80, 30'hA00, 6'd0, 1'b0);
        report_test();
    endtask

    task automatic test_call_ret();
        start_test("call and return");
        issue(OP_CALL, BEQ, 32'd0, 32'd0, 32'h200, 30'hB00, 6'd1, 1'b0);
        issue(OP_CALL, BEQ, 32'd0, 32'd0, 32'h200, 30'hB00, 6'd1, 1'b0);
        issue(OP_RET, BEQ, 32'h0000_2c04, 32'd0, 32'd0, 30'hB40, 6'd0, 1'b0);
        issue(OP_RET, BEQ, 32'h0000_2c04, 32'd0, 32'd0, 30'hB40, 6'd0, 1'b0);
        report_test();
    endtask

    task automatic test_flush();
        start_test("flush");
        issue(OP_JAL, BEQ, 32'd0, 32'd0, 32'h60, 30'hC00, 6'd2, 1'b1);
        issue(OP_COND, BNE, 32'd1, 32'd2, 32'h60, 30'hC10, 6'd0, 1'b1);
        issue(OP_JAL, BEQ, 32'd0, 32'd0, 32'h60, 30'hC00, 6'd2, 1'b0); // still a miss
        issue(OP_COND, BNE, 32'd1, 32'd2, 32'h60, 30'hC10, 6'd0, 1'b0);
        report_test();
    endtask

    initial begin
        lfsr         = 32'h3030_ae8a;
        total_errs   = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        valid        = 1'b0;
        flush        = 1'b0;
        operand_1    = '0;
        operand_2    = '0;
        offset       = '0;
        pc           = '0;
        {auipc, call, ret, jal, jalr} = '0;
        bnch_cond    = BEQ;
        rob_id       = '0;
        dest         = '0;
        for (int s = 0; s < `BRU_BTB_SETS; s++) begin
            model_q[0][s] = '0;
            model_q[1][s] = '0;
            model_lru[s]  = 1'b0;
        end
        repeat (10) @(posedge cpu_clock);
        #2;
        rst_n = 1'b1;
        @(posedge cpu_clock);
        #2;
        test_conditions();
        test_jumps();
        test_auipc();
        test_bimodal();
        test_call_ret();
        test_flush();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errs);
        if (total_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+source
source/branch_pkg.sv
source/btb_pkg.sv
source/btb.sv
source/branch_unit.sv
source/bru_top.sv
verification/tb_bru.sv

// ==== Bender.yml ====
package:
  name: bru

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/branch_pkg.sv
      - source/btb_pkg.sv
      - source/btb.sv
      - source/branch_unit.sv
      - source/bru_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verification/tb_bru.sv
